//--- src.f
logic/mipsPkg.sv
logic/decoder.sv
logic/regFile.sv
logic/stallControl.sv
logic/executeUnit.sv
logic/mipsPipeline.sv
verif/storeChecker.sv
verif/tbTop.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --top-module tbTop -f src.f -o tbTopSim
./obj_dir/tbTopSim > sim.log 2>&1
cat sim.log

# Exit status follows the search for the pass line
grep -qx "ALL TESTS PASSED" sim.log

//--- verif/tbTop.sv
`timescale 1ns/1ps

module tbTop;
    import mipsPkg::*;

    localparam int clkPeriod   = 100;
    localparam int resetCycles = 5;
    localparam int progWords   = 64;
    localparam int runCycles   = progWords * 40;
    localparam int watchdogNs  = 2 * (runCycles + resetCycles) * clkPeriod;

    logic                 clk = 1'b0;
    logic                 rst;
    logic [addrWidth-1:0] icacheAddr;
    logic                 icacheStall;
    logic [dataWidth-1:0] icacheRdata;
    logic                 dcacheRen;
    logic                 dcacheWen;
    logic [addrWidth-1:0] dcacheAddr;
    logic [dataWidth-1:0] dcacheWdata;
    logic                 dcacheStall;
    logic [dataWidth-1:0] dcacheRdata;
    logic [dataWidth-1:0] prog [progWords];
    logic [dataWidth-1:0] dmem [32];
    logic [31:0]          lfsrState;
    logic                 runDone;
    int                   errorCount;
    int                   storeCount;

    always #(clkPeriod / 2) clk = ~clk;

    // Taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
        return v;
    endfunction

    // Registers 1 to 7 only, for dense hazards
    function automatic logic [4:0] pickReg();
        logic [31:0] bits;
        bits = randBits(3);
        while (bits == 32'd0) begin
            bits = randBits(3);
        end
        return bits[4:0];
    endfunction

    function automatic logic [31:0] randomInst(input int idx);
        logic [31:0] bits;
        logic [3:0]  kind;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        int          target;
        bits = randBits(4);
        kind = bits[3:0];
        rs   = pickReg();
        rt   = pickReg();
        rd   = pickReg();
        case (kind)
            4'd0: return {opRtype, rs, rt, rd, 5'd0, fnAddu};
            4'd1: return {opRtype, rs, rt, rd, 5'd0, fnSubu};
            4'd2: return {opRtype, rs, rt, rd, 5'd0, fnAnd};
            4'd3: return {opRtype, rs, rt, rd, 5'd0, fnOr};
            4'd4: return {opRtype, rs, rt, rd, 5'd0, fnSlt};
            4'd5, 4'd6, 4'd7: begin
                bits = randBits(16);
                return {opAddiu, rs, rt, bits[15:0]};
            end
            4'd8, 4'd9: begin
                bits = randBits(5);
                return {opLw, 5'd0, rt, 9'd0, bits[4:0], 2'b00};
            end
            4'd10, 4'd11, 4'd12: begin
                bits = randBits(5);
                return {opSw, 5'd0, rt, 9'd0, bits[4:0], 2'b00};
            end
            default: begin
                // Forward by 1 to 4 words, never past the final self-loop
                bits   = randBits(2);
                target = idx + 1 + int'(bits);
                if (target > progWords - 1) begin
                    target = progWords - 1;
                end
                if (kind == 4'd13) begin
                    return {opBeq, rs, rt, 16'(target - idx - 1)};
                end else if (kind == 4'd14) begin
                    return {opBne, rs, rt, 16'(target - idx - 1)};
                end
                return {opJ, 26'(target)};
            end
        endcase
    endfunction

    assign icacheRdata = (icacheAddr < 30'(progWords)) ? prog[icacheAddr[5:0]] : '0;

    // Read data only on an enabled read
    assign dcacheRdata = dcacheRen ? dmem[dcacheAddr[4:0]] : '0;

    // Memory stage moves on only when neither cache stalls
    always @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < 32; k++) begin
                dmem[k] <= '0;
            end
        end else if (dcacheWen && !dcacheStall && !icacheStall) begin
            dmem[dcacheAddr[4:0]] <= dcacheWdata;
        end
    end

    mipsPipeline mipsPipeline_i (
        .clk           (clk),
        .rst           (rst),
        .icacheAddr_o  (icacheAddr),
        .icacheStall_i (icacheStall),
        .icacheRdata_i (icacheRdata),
        .dcacheRen_o   (dcacheRen),
        .dcacheWen_o   (dcacheWen),
        .dcacheAddr_o  (dcacheAddr),
        .dcacheWdata_o (dcacheWdata),
        .dcacheStall_i (dcacheStall),
        .dcacheRdata_i (dcacheRdata)
    );

    storeChecker storeChecker_i (
        .clk           (clk),
        .rst           (rst),
        .prog_i        (prog),
        .icacheAddr_i  (icacheAddr),
        .icacheStall_i (icacheStall),
        .dcacheStall_i (dcacheStall),
        .dcacheRen_i   (dcacheRen),
        .dcacheWen_i   (dcacheWen),
        .dcacheAddr_i  (dcacheAddr),
        .dcacheWdata_i (dcacheWdata),
        .done_i        (runDone),
        .errorCount_o  (errorCount),
        .storeCount_o  (storeCount)
    );

    initial begin
        logic [31:0] bits;
        rst         = 1'b1;
        icacheStall = 1'b0;
        dcacheStall = 1'b0;
        runDone     = 1'b0;
        lfsrState   = 32'h9edc4b20;
        for (int i = 0; i < progWords - 1; i++) begin
            prog[i] = randomInst(i);
        end
        prog[progWords-1] = {opJ, 26'(progWords - 1)};
        repeat (resetCycles) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (runCycles) begin
            @(posedge clk);
            #1;
            // Each stall with probability one quarter
            bits        = randBits(2);
            icacheStall = (bits[1:0] == 2'b00);
            bits        = randBits(2);
            dcacheStall = (bits[1:0] == 2'b00);
        end
        runDone = 1'b1;
        @(posedge clk);
        #1;
        $display("Stores taken: %0d, errors: %0d", storeCount, errorCount);
        if (errorCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdogNs);
        $display("Watchdog expired: the run did not end within %0d ns", watchdogNs);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- verif/storeChecker.sv
`timescale 1ns/1ps

module storeChecker (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [mipsPkg::dataWidth-1:0] prog_i [64],
    input  logic [mipsPkg::addrWidth-1:0] icacheAddr_i,
    input  logic                          icacheStall_i,
    input  logic                          dcacheStall_i,
    input  logic                          dcacheRen_i,
    input  logic                          dcacheWen_i,
    input  logic [mipsPkg::addrWidth-1:0] dcacheAddr_i,
    input  logic [mipsPkg::dataWidth-1:0] dcacheWdata_i,
    input  logic                          done_i,
    output int                            errorCount_o,
    output int                            storeCount_o
);
    import mipsPkg::*;

    localparam int maxSteps = 4096;

    logic [31:0] regs [32];
    logic [31:0] mem [32];
    logic [31:0] pcIdx;
    logic        atEnd;
    logic        resetPending;
    logic        finalDone;

    task automatic writeReg(input logic [4:0] r, input logic [31:0] v);
        if (r != 5'd0) begin
            regs[r] = v;
        end
    endtask

    // Instruction-level model, runs until the next store or the final self-loop
    task automatic runToStore(output logic found, output logic [29:0] addr,
                              output logic [31:0] data);
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sImm;
        logic [31:0] ea;
        logic [31:0] nextPc;
        logic [31:0] jTarget;
        int          steps;
        found = 1'b0;
        addr  = '0;
        data  = '0;
        steps = 0;
        while (!found && !atEnd && steps < maxSteps) begin
            inst    = (pcIdx < 32'd64) ? prog_i[pcIdx[5:0]] : '0;
            a       = regs[inst[25:21]];
            b       = regs[inst[20:16]];
            sImm    = {{16{inst[15]}}, inst[15:0]};
            ea      = a + sImm;
            jTarget = {6'd0, inst[25:0]};
            nextPc  = pcIdx + 32'd1;
            case (inst[31:26])
                opRtype: begin
                    case (inst[5:0])
                        fnAddu:  writeReg(inst[15:11], a + b);
                        fnSubu:  writeReg(inst[15:11], a - b);
                        fnAnd:   writeReg(inst[15:11], a & b);
                        fnOr:    writeReg(inst[15:11], a | b);
                        fnSlt:   writeReg(inst[15:11], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                        default: ;
                    endcase
                end
                opAddiu: writeReg(inst[20:16], ea);
                opLw:    writeReg(inst[20:16], mem[ea[6:2]]);
                opSw: begin
                    mem[ea[6:2]] = b;
                    found        = 1'b1;
                    addr         = ea[31:2];
                    data         = b;
                end
                opBeq:   if (a == b) nextPc = pcIdx + 32'd1 + sImm;
                opBne:   if (a != b) nextPc = pcIdx + 32'd1 + sImm;
                opJ:     if (jTarget == pcIdx) atEnd = 1'b1; else nextPc = jTarget;
                default: ;
            endcase
            if (!atEnd) begin
                pcIdx = nextPc;
            end
            steps++;
        end
    endtask

    always @(posedge clk) begin
        logic        found;
        logic [29:0] expAddr;
        logic [31:0] expData;
        int          leftover;
        if (rst) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] = '0;
                mem[k]  = '0;
            end
            pcIdx        = '0;
            atEnd        = 1'b0;
            resetPending = 1'b1;
            finalDone    = 1'b0;
            errorCount_o = 0;
            storeCount_o = 0;
        end else begin
            if (resetPending) begin
                resetPending = 1'b0;
                if (icacheAddr_i != '0 || dcacheRen_i || dcacheWen_i) begin
                    errorCount_o++;
                    $display("** Error: after reset icacheAddr_o=%h dcacheRen_o=%h dcacheWen_o=%h",
                             icacheAddr_i, dcacheRen_i, dcacheWen_i);
                end
            end
            if (dcacheWen_i && !dcacheStall_i && !icacheStall_i) begin
                storeCount_o++;
                runToStore(found, expAddr, expData);
                if (!found) begin
                    errorCount_o++;
                    $display("DUT took store %0d but the program model has no store left",
                             storeCount_o);
                end else begin
                    if (dcacheAddr_i != expAddr) begin
                        errorCount_o++;
                        $display("** Error: dcacheAddr_o store %0d expected %h got %h",
                                 storeCount_o, expAddr, dcacheAddr_i);
                    end
                    if (dcacheWdata_i != expData) begin
                        errorCount_o++;
                        $display("** Error: dcacheWdata_o store %0d expected %h got %h",
                                 storeCount_o, expData, dcacheWdata_i);
                    end
                end
            end
            if (done_i && !finalDone) begin
                finalDone = 1'b1;
                leftover  = 0;
                found     = 1'b1;
                while (found) begin
                    runToStore(found, expAddr, expData);
                    if (found) leftover++;
                end
                if (leftover != 0) begin
                    errorCount_o++;
                    $display("DUT never took %0d of the program's stores", leftover);
                end
                if (!atEnd) begin
                    errorCount_o++;
                    $display("Program model did not reach the final self-loop");
                end
            end
        end
    end

endmodule

//--- logic/mipsPipeline.sv
`timescale 1ns/1ps

module mipsPipeline (
    input  logic                          clk,
    input  logic                          rst,
    output logic [mipsPkg::addrWidth-1:0] icacheAddr_o,
    input  logic                          icacheStall_i,
    input  logic [mipsPkg::dataWidth-1:0] icacheRdata_i,
    output logic                          dcacheRen_o,
    output logic                          dcacheWen_o,
    output logic [mipsPkg::addrWidth-1:0] dcacheAddr_o,
    output logic [mipsPkg::dataWidth-1:0] dcacheWdata_o,
    input  logic                          dcacheStall_i,
    input  logic [mipsPkg::dataWidth-1:0] dcacheRdata_i
);
    import mipsPkg::*;

    logic [dataWidth-1:0]    pc;
    logic [dataWidth-1:0]    pcPlus4;
    logic [dataWidth-1:0]    ifIdInst;
    logic [dataWidth-1:0]    ifIdPcPlus4;
    idExT                    idEx;
    idExT                    idExNext;
    exMemT                   exMem;
    memWbT                   memWb;

    ctrlT                    idCtrl;
    logic [regAddrWidth-1:0] idRs;
    logic [regAddrWidth-1:0] idRt;
    logic [regAddrWidth-1:0] idRd;
    logic [dataWidth-1:0]    idImm;
    logic [dataWidth-1:0]    idRsData;
    logic [dataWidth-1:0]    idRtData;

    logic [dataWidth-1:0]    exAluRes;
    logic [dataWidth-1:0]    exStoreData;
    logic [dataWidth-1:0]    exTarget;
    logic                    exRedirect;
    logic [dataWidth-1:0]    wbData;

    logic writePc;
    logic writeId;
    logic writeEx;
    logic writeMem;
    logic writeWb;
    logic flushId;
    logic flushEx;

    // Fetch
    assign pcPlus4      = pc + 32'd4;
    assign icacheAddr_o = pc[dataWidth-1:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (writePc) begin
            pc <= exRedirect ? exTarget : pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flushId) begin
            ifIdInst    <= '0;
            ifIdPcPlus4 <= '0;
        end else if (writeId) begin
            ifIdInst    <= icacheRdata_i;
            ifIdPcPlus4 <= pcPlus4;
        end
    end

    // Decode
    decoder decoder_i (
        .inst_i (ifIdInst),
        .ctrl_o (idCtrl),
        .rs_o   (idRs),
        .rt_o   (idRt),
        .rd_o   (idRd),
        .imm_o  (idImm)
    );

    regFile regFile_i (
        .clk      (clk),
        .rst      (rst),
        .we_i     (memWb.regWrite),
        .waddr_i  (memWb.rd),
        .wdata_i  (wbData),
        .raddrA_i (idRs),
        .raddrB_i (idRt),
        .rdataA_o (idRsData),
        .rdataB_o (idRtData)
    );

    stallControl stallControl_i (
        .idRs_i        (idRs),
        .idRt_i        (idRt),
        .exMemRead_i   (idEx.ctrl.memRead),
        .exRd_i        (idEx.rd),
        .redirect_i    (exRedirect),
        .icacheStall_i (icacheStall_i),
        .dcacheStall_i (dcacheStall_i),
        .writePc_o     (writePc),
        .writeId_o     (writeId),
        .writeEx_o     (writeEx),
        .writeMem_o    (writeMem),
        .writeWb_o     (writeWb),
        .flushId_o     (flushId),
        .flushEx_o     (flushEx)
    );

    assign idExNext = '{ctrl: idCtrl, pcPlus4: ifIdPcPlus4, rs: idRs, rt: idRt, rd: idRd,
                        rsData: idRsData, rtData: idRtData, imm: idImm};

    always_ff @(posedge clk) begin
        if (rst || flushEx) begin
            idEx <= '0;
        end else if (writeEx) begin
            idEx <= idExNext;
        end
    end

    // Execute
    executeUnit executeUnit_i (
        .ex_i          (idEx),
        .memRes_i      (exMem.aluRes),
        .memRd_i       (exMem.rd),
        .memRegWrite_i (exMem.regWrite),
        .wbData_i      (wbData),
        .wbRd_i        (memWb.rd),
        .wbRegWrite_i  (memWb.regWrite),
        .aluRes_o      (exAluRes),
        .storeData_o   (exStoreData),
        .redirect_o    (exRedirect),
        .target_o      (exTarget)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            exMem <= '0;
        end else if (writeMem) begin
            exMem <= '{regWrite: idEx.ctrl.regWrite, memToReg: idEx.ctrl.memToReg,
                       memRead: idEx.ctrl.memRead, memWrite: idEx.ctrl.memWrite,
                       aluRes: exAluRes, rd: idEx.rd, storeData: exStoreData};
        end
    end

    // Memory access, held stable while either cache stalls
    assign dcacheRen_o   = exMem.memRead;
    assign dcacheWen_o   = exMem.memWrite;
    assign dcacheAddr_o  = exMem.aluRes[dataWidth-1:2];
    assign dcacheWdata_o = exMem.storeData;

    always_ff @(posedge clk) begin
        if (rst) begin
            memWb <= '0;
        end else if (writeWb) begin
            memWb <= '{regWrite: exMem.regWrite, memToReg: exMem.memToReg, rd: exMem.rd,
                       memData: dcacheRdata_i, aluRes: exMem.aluRes};
        end
    end

    // Write-back
    assign wbData = memWb.memToReg ? memWb.memData : memWb.aluRes;

endmodule

//--- logic/executeUnit.sv
`timescale 1ns/1ps

module executeUnit (
    input  mipsPkg::idExT                    ex_i,
    input  logic [mipsPkg::dataWidth-1:0]    memRes_i,
    input  logic [mipsPkg::regAddrWidth-1:0] memRd_i,
    input  logic                             memRegWrite_i,
    input  logic [mipsPkg::dataWidth-1:0]    wbData_i,
    input  logic [mipsPkg::regAddrWidth-1:0] wbRd_i,
    input  logic                             wbRegWrite_i,
    output logic [mipsPkg::dataWidth-1:0]    aluRes_o,
    output logic [mipsPkg::dataWidth-1:0]    storeData_o,
    output logic                             redirect_o,
    output logic [mipsPkg::dataWidth-1:0]    target_o
);
    import mipsPkg::*;

    fwdSelE               fwdA;
    fwdSelE               fwdB;
    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] rtFwd;
    logic [dataWidth-1:0] opB;
    logic                 equal;

    // Younger MEM result wins over WB
    function automatic fwdSelE pickSource(input logic [regAddrWidth-1:0] src);
        if (src == '0) begin
            return fwdReg;
        end else if (memRegWrite_i && memRd_i == src) begin
            return fwdMem;
        end else if (wbRegWrite_i && wbRd_i == src) begin
            return fwdWb;
        end
        return fwdReg;
    endfunction

    function automatic logic [dataWidth-1:0] fwdValue(input fwdSelE sel,
                                                      input logic [dataWidth-1:0] regVal);
        case (sel)
            fwdMem:  return memRes_i;
            fwdWb:   return wbData_i;
            default: return regVal;
        endcase
    endfunction

    always_comb begin
        fwdA  = pickSource(ex_i.rs);
        fwdB  = pickSource(ex_i.rt);
        opA   = fwdValue(fwdA, ex_i.rsData);
        rtFwd = fwdValue(fwdB, ex_i.rtData);
    end

    assign opB = ex_i.ctrl.aluSrcImm ? ex_i.imm : rtFwd;

    always_comb begin
        case (ex_i.ctrl.aluOp)
            aluSub:  aluRes_o = opA - opB;
            aluAnd:  aluRes_o = opA & opB;
            aluOr:   aluRes_o = opA | opB;
            aluSlt:  aluRes_o = {{(dataWidth-1){1'b0}}, $signed(opA) < $signed(opB)};
            default: aluRes_o = opA + opB;
        endcase
    end

    assign storeData_o = rtFwd;
    assign equal       = (opA == rtFwd);
    assign redirect_o  = ex_i.ctrl.jump
                         | (ex_i.ctrl.beq & equal)
                         | (ex_i.ctrl.bne & ~equal);

    // J keeps the upper PC bits, branches are relative to pcPlus4
    assign target_o = ex_i.ctrl.jump ? {ex_i.pcPlus4[31:28], ex_i.imm[27:0]}
                                     : ex_i.pcPlus4 + {ex_i.imm[29:0], 2'b00};

endmodule

//--- logic/stallControl.sv
`timescale 1ns/1ps

module stallControl (
    input  logic [mipsPkg::regAddrWidth-1:0] idRs_i,
    input  logic [mipsPkg::regAddrWidth-1:0] idRt_i,
    input  logic                             exMemRead_i,
    input  logic [mipsPkg::regAddrWidth-1:0] exRd_i,
    input  logic                             redirect_i,
    input  logic                             icacheStall_i,
    input  logic                             dcacheStall_i,
    output logic                             writePc_o,
    output logic                             writeId_o,
    output logic                             writeEx_o,
    output logic                             writeMem_o,
    output logic                             writeWb_o,
    output logic                             flushId_o,
    output logic                             flushEx_o
);

    logic cacheStall;
    logic loadUse;
    logic advanceFront;

    assign cacheStall = icacheStall_i | dcacheStall_i;
    assign loadUse    = exMemRead_i && (exRd_i != '0)
                        && ((exRd_i == idRs_i) || (exRd_i == idRt_i));

    // A taken redirect kills the dependent instruction anyway
    assign advanceFront = !cacheStall && (redirect_i || !loadUse);

    assign writePc_o  = advanceFront;
    assign writeId_o  = advanceFront;
    assign writeEx_o  = !cacheStall;
    assign writeMem_o = !cacheStall;
    assign writeWb_o  = !cacheStall;
    assign flushId_o  = !cacheStall && redirect_i;
    assign flushEx_o  = !cacheStall && (redirect_i || loadUse);

endmodule

//--- logic/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             we_i,
    input  logic [mipsPkg::regAddrWidth-1:0] waddr_i,
    input  logic [mipsPkg::dataWidth-1:0]    wdata_i,
    input  logic [mipsPkg::regAddrWidth-1:0] raddrA_i,
    input  logic [mipsPkg::regAddrWidth-1:0] raddrB_i,
    output logic [mipsPkg::dataWidth-1:0]    rdataA_o,
    output logic [mipsPkg::dataWidth-1:0]    rdataB_o
);
    import mipsPkg::*;

    logic [dataWidth-1:0] regs [numRegs];
    logic                 writeValid;

    assign writeValid = we_i && (waddr_i != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeValid) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Same-cycle write shows through to decode
    assign rdataA_o = (writeValid && raddrA_i == waddr_i) ? wdata_i : regs[raddrA_i];
    assign rdataB_o = (writeValid && raddrB_i == waddr_i) ? wdata_i : regs[raddrB_i];

endmodule

//--- logic/decoder.sv
`timescale 1ns/1ps

module decoder (
    input  logic [mipsPkg::dataWidth-1:0]    inst_i,
    output mipsPkg::ctrlT                    ctrl_o,
    output logic [mipsPkg::regAddrWidth-1:0] rs_o,
    output logic [mipsPkg::regAddrWidth-1:0] rt_o,
    output logic [mipsPkg::regAddrWidth-1:0] rd_o,
    output logic [mipsPkg::dataWidth-1:0]    imm_o
);
    import mipsPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    logic       rdIsRt;

    assign opcode = inst_i[31:26];
    assign funct  = inst_i[5:0];
    assign rs_o   = inst_i[25:21];
    assign rt_o   = inst_i[20:16];

    always_comb begin
        ctrl_o = '0;
        rdIsRt = 1'b0;
        case (opcode)
            opRtype: begin
                ctrl_o.regWrite = 1'b1;
                case (funct)
                    fnAddu:  ctrl_o.aluOp = aluAdd;
                    fnSubu:  ctrl_o.aluOp = aluSub;
                    fnAnd:   ctrl_o.aluOp = aluAnd;
                    fnOr:    ctrl_o.aluOp = aluOr;
                    fnSlt:   ctrl_o.aluOp = aluSlt;
                    // Unknown function code behaves as a no-op
                    default: ctrl_o.regWrite = 1'b0;
                endcase
            end
            opAddiu: begin
                ctrl_o.regWrite  = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
                rdIsRt           = 1'b1;
            end
            opLw: begin
                ctrl_o.regWrite  = 1'b1;
                ctrl_o.memToReg  = 1'b1;
                ctrl_o.memRead   = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
                rdIsRt           = 1'b1;
            end
            opSw: begin
                ctrl_o.memWrite  = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
            end
            opBeq:   ctrl_o.beq  = 1'b1;
            opBne:   ctrl_o.bne  = 1'b1;
            opJ:     ctrl_o.jump = 1'b1;
            default: ;
        endcase
    end

    // Non-writing instructions carry register 0 as destination
    assign rd_o = !ctrl_o.regWrite ? '0 : (rdIsRt ? inst_i[20:16] : inst_i[15:11]);

    // Jump target as a byte address within the current 256 MB region
    assign imm_o = ctrl_o.jump ? {4'b0000, inst_i[25:0], 2'b00}
                               : {{16{inst_i[15]}}, inst_i[15:0]};

endmodule

//--- logic/mipsPkg.sv
package mipsPkg;

    localparam int dataWidth    = 32;
    localparam int addrWidth    = 30;
    localparam int regAddrWidth = 5;
    localparam int numRegs      = 32;

    // Major opcodes
    localparam logic [5:0] opRtype = 6'h00;
    localparam logic [5:0] opJ     = 6'h02;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] opBne   = 6'h05;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;

    // R-type function codes
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnSlt  = 6'h2a;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOpE;

    typedef enum logic [1:0] {
        fwdReg,
        fwdMem,
        fwdWb
    } fwdSelE;

    typedef struct packed {
        logic  regWrite;
        logic  memToReg;
        logic  memRead;
        logic  memWrite;
        logic  aluSrcImm;
        logic  beq;
        logic  bne;
        logic  jump;
        aluOpE aluOp;
    } ctrlT;

    typedef struct packed {
        ctrlT                    ctrl;
        logic [dataWidth-1:0]    pcPlus4;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] rd;
        logic [dataWidth-1:0]    rsData;
        logic [dataWidth-1:0]    rtData;
        logic [dataWidth-1:0]    imm;
    } idExT;

    typedef struct packed {
        logic                    regWrite;
        logic                    memToReg;
        logic                    memRead;
        logic                    memWrite;
        logic [dataWidth-1:0]    aluRes;
        logic [regAddrWidth-1:0] rd;
        logic [dataWidth-1:0]    storeData;
    } exMemT;

    typedef struct packed {
        logic                    regWrite;
        logic                    memToReg;
        logic [regAddrWidth-1:0] rd;
        logic [dataWidth-1:0]    memData;
        logic [dataWidth-1:0]    aluRes;
    } memWbT;

endpackage
